// File: hw/renamePkg.sv
// sizes and vector types shared by the rename free list, its producer and the map
package renamePkg;

  // ------------------------------
  // widths of the rename stage
  // ------------------------------

  // rename and commit width.
  localparam int numLanes = 4;

  localparam int numArchRegs = 32;
  localparam int numPhysRegs = 64;

  // every physical tag not mapped at reset starts on the free list.
  localparam int freeListSize = numPhysRegs - numArchRegs;

  // ------------------------------
  // vector types
  // ------------------------------

  typedef logic [4:0] archTagT;
  typedef logic [5:0] physTagT;

  // index into the free list.
  typedef logic [4:0] flPtrT;

  // number of free entries, 0 to freeListSize inclusive.
  typedef logic [5:0] flCntT;

endpackage

// File: hw/freeListRam.sv
// free-list storage with four asynchronous read ports and four synchronous write ports
`timescale 1ns/1ps

module freeListRam
(
  input  logic               clk,
  input  logic               reset,
  input  renamePkg::flPtrT   readAddr_i  [renamePkg::numLanes],
  output renamePkg::physTagT readData_o  [renamePkg::numLanes],
  input  logic               writeEn_i   [renamePkg::numLanes],
  input  renamePkg::flPtrT   writeAddr_i [renamePkg::numLanes],
  input  renamePkg::physTagT writeData_i [renamePkg::numLanes]
);

  renamePkg::physTagT mem [renamePkg::freeListSize];

  // ------------------------------
  // read ports
  // ------------------------------

  always_comb
  begin
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      readData_o[k] = mem[readAddr_i[k]];
    end
  end

  // ------------------------------
  // write ports
  // ------------------------------

  // on reset the list holds every physical tag above the architectural range.
  // the write lanes use consecutive addresses, so two lanes never hit the same entry.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < renamePkg::freeListSize; i++)
      begin
        mem[i] <= renamePkg::physTagT'(renamePkg::numArchRegs + i);
      end
    end
    else
    begin
      for (int k = 0; k < renamePkg::numLanes; k++)
      begin
        if (writeEn_i[k])
        begin
          mem[writeAddr_i[k]] <= writeData_i[k];
        end
      end
    end
  end

endmodule

// File: hw/specFreeList.sv
// speculative free list with head, tail and count control, lane allocation and a checkpoint
`timescale 1ns/1ps

module specFreeList
(
  input  logic               clk,
  input  logic               reset,
  input  logic               stall_i,
  input  logic               takeCkpt_i,
  input  logic               restore_i,
  input  logic               allocReq_i  [renamePkg::numLanes],
  input  logic               pushValid_i [renamePkg::numLanes],
  input  renamePkg::physTagT pushTag_i   [renamePkg::numLanes],
  output logic               allocOk_o,
  output renamePkg::physTagT allocTag_o  [renamePkg::numLanes]
);

  renamePkg::flPtrT   head;
  renamePkg::flPtrT   tail;
  renamePkg::flCntT   count;
  renamePkg::flPtrT   ckptHead;
  renamePkg::flPtrT   readAddr  [renamePkg::numLanes];
  renamePkg::physTagT readData  [renamePkg::numLanes];
  renamePkg::flPtrT   writeAddr [renamePkg::numLanes];
  renamePkg::flCntT   popCnt;
  renamePkg::flCntT   pushCnt;
  renamePkg::flPtrT   tailNext;
  renamePkg::flPtrT   restoreDist;
  renamePkg::flCntT   restoreCnt;

  freeListRam freeListRamInst
  (
    .clk         (clk),
    .reset       (reset),
    .readAddr_i  (readAddr),
    .readData_o  (readData),
    .writeEn_i   (pushValid_i),
    .writeAddr_i (writeAddr),
    .writeData_i (pushTag_i)
  );

  // ------------------------------
  // lane addresses
  // ------------------------------

  // popCnt runs as the rank of each lane, i.e. the number of requests below it.
  // the pointer width equals the list size, so the sums wrap on their own.
  always_comb
  begin
    popCnt  = '0;
    pushCnt = '0;
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      readAddr[k]  = head + renamePkg::flPtrT'(popCnt);
      writeAddr[k] = tail + renamePkg::flPtrT'(k);
      if (allocReq_i[k])
      begin
        popCnt = popCnt + 1'b1;
      end
      if (pushValid_i[k])
      begin
        pushCnt = pushCnt + 1'b1;
      end
    end
  end

  assign allocOk_o = (count >= renamePkg::numLanes) && !stall_i;

  always_comb
  begin
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      allocTag_o[k] = allocReq_i[k] ? readData[k] : '0;
    end
  end

  // ------------------------------
  // head, tail and count
  // ------------------------------

  assign tailNext    = tail + renamePkg::flPtrT'(pushCnt);
  assign restoreDist = tailNext - ckptHead;

  // a restored head that meets the tail means the list is full again.
  assign restoreCnt = (restoreDist == '0) ? renamePkg::flCntT'(renamePkg::freeListSize)
                                          : renamePkg::flCntT'(restoreDist);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      head     <= '0;
      tail     <= '0;
      count    <= renamePkg::flCntT'(renamePkg::freeListSize);
      ckptHead <= '0;
    end
    else
    begin
      // commits always land, whatever happens on the allocation side.
      tail <= tailNext;
      if (takeCkpt_i)
      begin
        ckptHead <= head;
      end
      if (restore_i)
      begin
        head  <= ckptHead;
        count <= restoreCnt;
      end
      else if (!allocOk_o)
      begin
        count <= count + pushCnt;
      end
      else
      begin
        head  <= head + renamePkg::flPtrT'(popCnt);
        count <= count - popCnt + pushCnt;
      end
    end
  end

endmodule

// File: hw/commitPacker.sv
// compaction of scattered commit lanes into dense push lanes, registered for one cycle
`timescale 1ns/1ps

module commitPacker
(
  input  logic               clk,
  input  logic               reset,
  input  logic               commitValid_i [renamePkg::numLanes],
  input  renamePkg::physTagT commitTag_i   [renamePkg::numLanes],
  output logic               pushValid_o   [renamePkg::numLanes],
  output renamePkg::physTagT pushTag_o     [renamePkg::numLanes]
);

  logic               packedValid [renamePkg::numLanes];
  renamePkg::physTagT packedTag   [renamePkg::numLanes];

  // each valid lane moves down to the slot given by the number of valid lanes below it.
  always_comb
  begin
    logic [2:0] pos;
    pos = '0;
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      packedValid[k] = 1'b0;
      packedTag[k]   = '0;
    end
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      if (commitValid_i[k])
      begin
        packedValid[pos[1:0]] = 1'b1;
        packedTag[pos[1:0]]   = commitTag_i[k];
        pos = pos + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      if (reset)
      begin
        pushValid_o[k] <= 1'b0;
      end
      else
      begin
        pushValid_o[k] <= packedValid[k];
      end
      pushTag_o[k] <= packedTag[k];
    end
  end

endmodule

// File: hw/renameMap.sv
// architectural-to-physical map table with lane writes, source lookups and one shadow copy
`timescale 1ns/1ps

module renameMap
(
  input  logic               clk,
  input  logic               reset,
  input  logic               takeCkpt_i,
  input  logic               restore_i,
  input  logic               allocReq_i [renamePkg::numLanes],
  input  logic               allocOk_i,
  input  renamePkg::archTagT destArch_i [renamePkg::numLanes],
  input  renamePkg::physTagT allocTag_i [renamePkg::numLanes],
  input  renamePkg::archTagT srcArch_i  [renamePkg::numLanes],
  output renamePkg::physTagT srcPhys_o  [renamePkg::numLanes]
);

  renamePkg::physTagT mapTable  [renamePkg::numArchRegs];
  renamePkg::physTagT shadowMap [renamePkg::numArchRegs];

  // ------------------------------
  // source lookups
  // ------------------------------

  // sources see the map as it stands, without this cycle's destinations.
  always_comb
  begin
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      srcPhys_o[k] = mapTable[srcArch_i[k]];
    end
  end

  // ------------------------------
  // table and shadow update
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int r = 0; r < renamePkg::numArchRegs; r++)
      begin
        mapTable[r]  <= renamePkg::physTagT'(r);
        shadowMap[r] <= renamePkg::physTagT'(r);
      end
    end
    else
    begin
      // the shadow takes the table from before this cycle's writes.
      if (takeCkpt_i)
      begin
        shadowMap <= mapTable;
      end
      if (restore_i)
      begin
        mapTable <= shadowMap;
      end
      else if (allocOk_i)
      begin
        // later lanes are younger, so the last write to a register wins.
        for (int k = 0; k < renamePkg::numLanes; k++)
        begin
          if (allocReq_i[k])
          begin
            mapTable[destArch_i[k]] <= allocTag_i[k];
          end
        end
      end
    end
  end

endmodule

// File: hw/renameTop.sv
// rename stage top with the commit packer, the speculative free list and the map table
`timescale 1ns/1ps

module renameTop
(
  input  logic               clk,
  input  logic               reset,
  input  logic               stall_i,
  input  logic               takeCkpt_i,
  input  logic               restore_i,
  input  logic               allocReq_i    [renamePkg::numLanes],
  input  renamePkg::archTagT destArch_i    [renamePkg::numLanes],
  input  renamePkg::archTagT srcArch_i     [renamePkg::numLanes],
  input  logic               commitValid_i [renamePkg::numLanes],
  input  renamePkg::physTagT commitTag_i   [renamePkg::numLanes],
  output logic               allocOk_o,
  output renamePkg::physTagT allocTag_o    [renamePkg::numLanes],
  output renamePkg::physTagT srcPhys_o     [renamePkg::numLanes]
);

  logic               pushValid [renamePkg::numLanes];
  renamePkg::physTagT pushTag   [renamePkg::numLanes];

  commitPacker commitPackerInst
  (
    .clk           (clk),
    .reset         (reset),
    .commitValid_i (commitValid_i),
    .commitTag_i   (commitTag_i),
    .pushValid_o   (pushValid),
    .pushTag_o     (pushTag)
  );

  specFreeList specFreeListInst
  (
    .clk         (clk),
    .reset       (reset),
    .stall_i     (stall_i),
    .takeCkpt_i  (takeCkpt_i),
    .restore_i   (restore_i),
    .allocReq_i  (allocReq_i),
    .pushValid_i (pushValid),
    .pushTag_i   (pushTag),
    .allocOk_o   (allocOk_o),
    .allocTag_o  (allocTag_o)
  );

  renameMap renameMapInst
  (
    .clk        (clk),
    .reset      (reset),
    .takeCkpt_i (takeCkpt_i),
    .restore_i  (restore_i),
    .allocReq_i (allocReq_i),
    .allocOk_i  (allocOk_o),
    .destArch_i (destArch_i),
    .allocTag_i (allocTag_o),
    .srcArch_i  (srcArch_i),
    .srcPhys_o  (srcPhys_o)
  );

endmodule

// File: dv/renameChk_chk.sv
// concurrent assertions on the free-list count, the allocation level and the checkpoint strobes
`timescale 1ns/1ps

module renameChk
(
  input logic             clk,
  input logic             reset,
  input renamePkg::flCntT count_i,
  input logic             allocOk_i,
  input logic             takeCkpt_i,
  input logic             restore_i
);

  int failCount = 0;

  countBound: assert property (@(posedge clk) disable iff (reset)
    count_i <= renamePkg::freeListSize)
    else begin failCount++; $error("free-list count is above the list size"); end

  shortList: assert property (@(posedge clk) disable iff (reset)
    (count_i < renamePkg::numLanes) |-> !allocOk_i)
    else begin failCount++; $error("allocation granted with fewer than four free entries"); end

  // one checkpoint slot, so a save and a restore in the same cycle are illegal.
  ckptExclusive: assert property (@(posedge clk) disable iff (reset)
    !(takeCkpt_i && restore_i))
    else begin failCount++; $error("checkpoint and restore requested together"); end

endmodule

bind specFreeList renameChk renameChkInst
(
  .clk        (clk),
  .reset      (reset),
  .count_i    (count),
  .allocOk_i  (allocOk_o),
  .takeCkpt_i (takeCkpt_i),
  .restore_i  (restore_i)
);

// File: dv/renameTb.sv
// testbench for the rename stage with stimulus, reference model, compare process and watchdog
`timescale 1ns/1ps

module renameTb;

  logic clk = 1'b0;
  logic reset, stall, takeCkpt, restore, allocOk, expOk;
  logic allocReq [renamePkg::numLanes];
  logic commitValid [renamePkg::numLanes];
  renamePkg::archTagT destArch [renamePkg::numLanes];
  renamePkg::archTagT srcArch [renamePkg::numLanes];
  renamePkg::physTagT commitTag [renamePkg::numLanes];
  renamePkg::physTagT allocTag [renamePkg::numLanes];
  renamePkg::physTagT srcPhys [renamePkg::numLanes];

  // reference model of the list, the map and the tags in flight.
  renamePkg::physTagT fl [renamePkg::freeListSize];
  renamePkg::physTagT mMap [renamePkg::numArchRegs];
  renamePkg::physTagT mShadow [renamePkg::numArchRegs];
  renamePkg::physTagT pend [$];
  renamePkg::physTagT inFlight [$];
  int mHead, mTail, mCount, mCkptHead, sinceCkpt;
  logic ckptActive;
  int errCount, checkCount, errBase, testNum, totalErr;

  renameTop UUT
  (
    .clk (clk), .reset (reset), .stall_i (stall), .takeCkpt_i (takeCkpt),
    .restore_i (restore), .allocReq_i (allocReq), .destArch_i (destArch),
    .srcArch_i (srcArch), .commitValid_i (commitValid), .commitTag_i (commitTag),
    .allocOk_o (allocOk), .allocTag_o (allocTag), .srcPhys_o (srcPhys)
  );

  always #4 clk = ~clk;

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp)
    begin
      errCount++;
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // a requesting lane takes the entry at head plus its rank.
  function automatic renamePkg::physTagT refTag(input int k);
    int rank;
    rank = 0;
    for (int j = 0; j < k; j++)
    begin
      if (allocReq[j])
      begin
        rank++;
      end
    end
    return allocReq[k] ? fl[(mHead + rank) % renamePkg::freeListSize] : '0;
  endfunction

  task automatic updateModel();
    renamePkg::physTagT grant [renamePkg::numLanes];
    int pops;
    int pushes;
    pops = 0;
    pushes = 0;
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      grant[k] = refTag(k);
      if (allocReq[k])
      begin
        pops++;
      end
    end
    if (takeCkpt)
    begin
      mCkptHead = mHead;
      mShadow = mMap;
      ckptActive = 1'b1;
      sinceCkpt = 0;
    end
    // packed commits from the previous cycle land at the tail.
    while (pend.size() > 0)
    begin
      fl[mTail] = pend.pop_front();
      mTail = (mTail + 1) % renamePkg::freeListSize;
      pushes++;
    end
    if (restore)
    begin
      mHead = mCkptHead;
      mCount = (mTail - mHead + renamePkg::freeListSize) % renamePkg::freeListSize;
      if (mCount == 0)
      begin
        mCount = renamePkg::freeListSize;
      end
      mMap = mShadow;
      ckptActive = 1'b0;
      repeat (sinceCkpt) void'(inFlight.pop_back());
    end
    else if (expOk)
    begin
      for (int k = 0; k < renamePkg::numLanes; k++)
      begin
        if (allocReq[k])
        begin
          mMap[destArch[k]] = grant[k];
          inFlight.push_back(grant[k]);
        end
      end
      mHead = (mHead + pops) % renamePkg::freeListSize;
      mCount = mCount + pushes - pops;
      if (ckptActive)
      begin
        sinceCkpt += pops;
      end
    end
    else
    begin
      mCount = mCount + pushes;
    end
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      if (commitValid[k])
      begin
        pend.push_back(commitTag[k]);
      end
    end
  endtask

  // ------------------------------
  // compare process
  // ------------------------------

  always @(negedge clk)
  begin
    #2;
    if (!reset)
    begin
      expOk = (mCount >= renamePkg::numLanes) && !stall;
      checkVal("allocOk_o", allocOk, expOk);
      for (int k = 0; k < renamePkg::numLanes; k++)
      begin
        checkVal($sformatf("allocTag_o[%0d]", k), allocTag[k], refTag(k));
        checkVal($sformatf("srcPhys_o[%0d]", k), srcPhys[k], mMap[srcArch[k]]);
      end
      updateModel();
    end
  end

  // commits only return tags handed out before an open checkpoint.
  task automatic driveCycle(input logic [3:0] reqMask, input logic stallV, input logic ckptV,
                            input logic restoreV, input logic [3:0] commitMask);
    int avail;
    @(negedge clk);
    avail = inFlight.size() - (ckptActive ? sinceCkpt : 0);
    stall = stallV;
    takeCkpt = ckptV;
    restore = restoreV;
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      allocReq[k] = reqMask[k];
      destArch[k] = renamePkg::archTagT'($urandom);
      srcArch[k] = renamePkg::archTagT'($urandom);
      commitValid[k] = commitMask[k] && (avail > 0);
      if (commitValid[k])
      begin
        commitTag[k] = inFlight.pop_front();
        avail--;
      end
      else
      begin
        commitTag[k] = renamePkg::physTagT'($urandom);
      end
    end
    #3;
  endtask

  task automatic endTest(input string name);
    testNum++;
    $display("test %0d (%s) finished with %0d errors", testNum, name, errCount - errBase);
    errBase = errCount;
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  initial
  begin
    int r;
    void'($urandom(40302));
    {errCount, checkCount, errBase, testNum} = '0;
    {mHead, mTail, mCkptHead, sinceCkpt} = '0;
    mCount = renamePkg::freeListSize;
    ckptActive = 1'b0;
    for (int i = 0; i < renamePkg::freeListSize; i++)
    begin
      fl[i] = renamePkg::physTagT'(renamePkg::numArchRegs + i);
    end
    for (int i = 0; i < renamePkg::numArchRegs; i++)
    begin
      mMap[i] = renamePkg::physTagT'(i);
      mShadow[i] = renamePkg::physTagT'(i);
    end
    {reset, stall, takeCkpt, restore} = 4'b1000;
    for (int k = 0; k < renamePkg::numLanes; k++)
    begin
      {allocReq[k], commitValid[k], destArch[k], srcArch[k], commitTag[k]} = '0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;

    driveCycle(4'hf, 1'b0, 1'b0, 1'b0, 4'h0);
    endTest("tags after reset");
    repeat (8) driveCycle(4'($urandom), 1'b0, 1'b0, 1'b0, 4'h0);
    endTest("sparse request masks");
    repeat (9) driveCycle(4'hf, 1'b0, 1'b0, 1'b0, 4'h0);
    repeat (3) driveCycle(4'h0, 1'b0, 1'b0, 1'b0, 4'hf);
    repeat (3) driveCycle(4'hf, 1'b0, 1'b0, 1'b0, 4'h0);
    endTest("drain and refill");
    repeat (6) driveCycle(4'hf, 1'b1, 1'b0, 1'b0, 4'($urandom));
    endTest("stall with commits");
    driveCycle(4'h0, 1'b0, 1'b1, 1'b0, 4'h0);
    repeat (3) driveCycle(4'($urandom), 1'b0, 1'b0, 1'b0, 4'hf);
    driveCycle(4'hf, 1'b0, 1'b0, 1'b1, 4'hf);
    repeat (2) driveCycle(4'hf, 1'b0, 1'b0, 1'b0, 4'h0);
    endTest("checkpoint and restore");
    repeat (400)
    begin
      r = $urandom % 100;
      driveCycle(4'($urandom), r < 10, !ckptActive && r >= 90, ckptActive && r >= 94,
                 4'($urandom));
    end
    endTest("random mix with wrap");

    driveCycle(4'h0, 1'b0, 1'b0, 1'b0, 4'h0);
    totalErr = errCount + UUT.specFreeListInst.renameChkInst.failCount;
    $display("%0d tests, %0d checks, %0d errors", testNum, checkCount, totalErr);
    if (totalErr == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

  initial
  begin
    int testCycles;
    testCycles = 5 + 1 + 1 + 8 + 15 + 6 + 7 + 400 + 1;
    #(testCycles * 8 + 400);
    $display("timeout: the tests did not finish in the expected time");
    $display("Verification failed");
    $finish;
  end

endmodule

// File: flist.f
hw/renamePkg.sv
hw/freeListRam.sv
hw/specFreeList.sv
hw/commitPacker.sv
hw/renameMap.sv
hw/renameTop.sv
dv/renameChk_chk.sv
dv/renameTb.sv
